// File: all.f
dvid_pkg.sv
raster_timing.sv
frame_store_ctrl.sv
tmds_symbol_select.sv
tmds_serializer.sv
dvid_top.sv
tb_dvid_top.sv

// File: tb_dvid_top.sv
module tb_dvid_top;

	// expected TMDS words
	localparam logic [9:0] hi_word  = 10'b1011110000;
	localparam logic [9:0] lo_word  = 10'b0111110000;
	localparam logic [9:0] ctl_00   = 10'b1101010100;
	localparam logic [9:0] ctl_01   = 10'b0010101011;
	localparam logic [9:0] ctl_10   = 10'b0101010100;
	localparam logic [9:0] ctl_11   = 10'b1010101011;
	localparam logic [9:0] clk_word = 10'b0000011111;

	localparam int line_px   = 800;
	localparam int max_words = 36000;
	localparam int last_line = 43; // last line any test looks at
	localparam int run_limit = (last_line + 2) * line_px * 5 * 100 + 20000;

	logic        latch_high_speed;
	logic        rst;
	logic        rec_n;
	logic [7:0]  key;
	logic [17:0] sram_addr;
	logic        sram_we_n;
	logic [7:0]  sram_dq_out;
	logic        sram_dq_en;
	logic [7:0]  sram_dq_in;
	logic [1:0]  tmds_red;
	logic [1:0]  tmds_green;
	logic [1:0]  tmds_blue;
	logic [1:0]  tmds_clk;

	logic [7:0]  sram_mem [0:(1 << 18) - 1];
	logic [9:0]  word_red [0:max_words-1];
	logic [9:0]  word_green [0:max_words-1];
	logic [9:0]  word_blue [0:max_words-1];
	logic [9:0]  red_hist;
	logic [9:0]  green_hist;
	logic [9:0]  blue_hist;
	logic [9:0]  clk_hist;
	bit          locked;
	int          lock_edge;
	int          pair_cnt;
	int          word_cnt;
	int          clk_bad;
	int          edge_cnt;
	int          n_pass;
	int          n_fail;
	int          test_errs;

	dvid_top dvid_top_i (
		.latch_high_speed (latch_high_speed),
		.rst              (rst),
		.rec_n            (rec_n),
		.key              (key),
		.sram_addr        (sram_addr),
		.sram_we_n        (sram_we_n),
		.sram_dq_out      (sram_dq_out),
		.sram_dq_en       (sram_dq_en),
		.sram_dq_in       (sram_dq_in),
		.tmds_red         (tmds_red),
		.tmds_green       (tmds_green),
		.tmds_blue        (tmds_blue),
		.tmds_clk         (tmds_clk)
	);

	initial begin
		latch_high_speed = 1'b0;
		forever #50 latch_high_speed = ~latch_high_speed;
	end

	// ------------------------------------------------------------------------
	// SRAM model and bit clock counter
	// ------------------------------------------------------------------------
	assign sram_dq_in = sram_mem[sram_addr];

	always @(posedge latch_high_speed) begin
		if (!sram_we_n) begin
			sram_mem[sram_addr] <= sram_dq_out;
		end
	end

	always @(posedge latch_high_speed) begin
		if (rst) begin
			edge_cnt <= 0;
		end else begin
			edge_cnt <= edge_cnt + 1; // pixel j strobes on count 5*(j+1)
		end
	end

	// ------------------------------------------------------------------------
	// lane deserializer, framed on the clock lane pattern
	// ------------------------------------------------------------------------
	always @(negedge latch_high_speed) begin
		if (rst) begin
			{red_hist, green_hist, blue_hist, clk_hist} = '0;
			locked    = 1'b0;
			lock_edge = 0;
			pair_cnt  = 0;
			word_cnt  = 0;
			clk_bad   = 0;
		end else begin
			red_hist   = {tmds_red, red_hist[9:2]};
			green_hist = {tmds_green, green_hist[9:2]};
			blue_hist  = {tmds_blue, blue_hist[9:2]};
			clk_hist   = {tmds_clk, clk_hist[9:2]};
			pair_cnt   = pair_cnt + 1;
			if (!locked && clk_hist == clk_word) begin
				locked    = 1'b1; // first load seen, this is word 0
				lock_edge = edge_cnt;
				pair_cnt  = 5;
			end
			if (locked && pair_cnt == 5) begin
				pair_cnt = 0;
				if (clk_hist !== clk_word) clk_bad++;
				if (word_cnt < max_words) begin
					word_red[word_cnt]   = red_hist;
					word_green[word_cnt] = green_hist;
					word_blue[word_cnt]  = blue_hist;
				end
				word_cnt++;
			end
		end
	end

	// ------------------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------------------
	task automatic value_error(input string name, input string what,
		input logic [31:0] exp, input logic [31:0] act);
		$display("[FAIL] %s: %s expected %0h actual %0h", name, what, exp, act);
		n_fail++;
		test_errs++;
	endtask

	task automatic finish_test(input string name);
		$display("test %s finished with %0d errors", name, test_errs);
	endtask

	task automatic load_sram(input logic [7:0] val, input bit by_addr);
		for (int a = 0; a < (1 << 18); a++) begin
			sram_mem[a] = by_addr ? (8'(a) ^ 8'(a >> 8) ^ 8'(a >> 16)) : val;
		end
	endtask

	// returns just after the strobe edge of pixel p
	task automatic wait_pixel(input int p);
		while (edge_cnt < 5 * (p + 1)) begin
			@(posedge latch_high_speed);
			#10;
		end
		if (edge_cnt != 5 * (p + 1)) begin
			$display("testbench fell behind the raster at pixel %0d", p);
			n_fail++;
			test_errs++;
		end
	endtask

	task automatic wait_word(input int n);
		while (word_cnt <= n) begin
			@(posedge latch_high_speed);
			#10;
		end
	endtask

	function automatic int exp_addr(input int h, input int v, input logic [7:0] k);
		int a;
		a = (h - 144) / 2 + ((v - 35) / 2) * 320;
		if (k[7]) a = a + 78000;
		return a;
	endfunction

	function automatic logic [7:0] exp_byte(input int h, input int v, input logic [7:0] k);
		logic [6:0] pat;
		pat = ~(7'(h) ^ 7'(v));
		return (pat > k[6:0]) ? 8'hff : 8'h00;
	endfunction

	task automatic check_word(input string name, input int n,
		input logic [9:0] er, input logic [9:0] eg, input logic [9:0] eb);
		string tag;
		wait_word(n);
		tag = $sformatf("word %0d", n);
		if (word_red[n] !== er) value_error(name, {tag, " red"}, er, word_red[n]);
		else n_pass++;
		if (word_green[n] !== eg) value_error(name, {tag, " green"}, eg, word_green[n]);
		else n_pass++;
		if (word_blue[n] !== eb) value_error(name, {tag, " blue"}, eb, word_blue[n]);
		else n_pass++;
	endtask

	task automatic check_idle(input string name);
		if (sram_we_n !== 1'b1) value_error(name, "sram_we_n", 1, sram_we_n);
		else n_pass++;
		if (sram_dq_en !== 1'b0) value_error(name, "sram_dq_en", 0, sram_dq_en);
		else n_pass++;
		if ({tmds_red, tmds_green, tmds_blue, tmds_clk} !== 8'h00) begin
			value_error(name, "lane outputs", 0, {tmds_red, tmds_green, tmds_blue, tmds_clk});
		end else begin
			n_pass++;
		end
	endtask

	// ------------------------------------------------------------------------
	// directed tests
	// ------------------------------------------------------------------------
	task automatic test_reset();
		test_errs = 0;
		for (int i = 0; i < 4; i++) begin
			@(posedge latch_high_speed);
			#10;
			check_idle("reset");
		end
		rst = 1'b0;
		@(posedge latch_high_speed);
		#10;
		check_idle("reset");
		finish_test("reset");
	endtask

	task automatic test_word0();
		test_errs = 0;
		check_word("word0", 0, '0, '0, '0);
		// first load five clocks after reset, its word leaves over the next five
		if (lock_edge != 10) value_error("word0", "word 0 end clock", 10, lock_edge);
		else n_pass++;
		finish_test("word0");
	endtask

	task automatic test_blank(input string name, input int line);
		logic [9:0] eb;
		test_errs = 0;
		for (int h = 0; h < line_px; h++) begin
			case ({line < 2, h < 96}) // {vsync,hsync}
				2'b00:   eb = ctl_00;
				2'b01:   eb = ctl_01;
				2'b10:   eb = ctl_10;
				default: eb = ctl_11;
			endcase
			check_word(name, line * line_px + h + 1, ctl_00, ctl_00, eb);
		end
		finish_test(name);
	endtask

	task automatic test_record(input string name, input int line0, input logic [7:0] k);
		int         ea;
		logic [7:0] eb;
		test_errs = 0;
		wait_pixel(line0 * line_px - 1);
		rec_n = 1'b0;
		key   = k;
		for (int v = line0; v < line0 + 2; v++) begin
			for (int h = 144; h < 784; h++) begin
				wait_pixel(v * line_px + h);
				ea = exp_addr(h, v, k);
				eb = exp_byte(h, v, k);
				if (sram_addr !== 18'(ea)) value_error(name, "sram_addr", ea, sram_addr);
				else n_pass++;
				if (sram_dq_out !== eb) value_error(name, "record byte", eb, sram_dq_out);
				else n_pass++;
				if (sram_we_n !== ea[0]) value_error(name, "sram_we_n", ea[0], sram_we_n);
				else n_pass++;
				if (sram_dq_en !== 1'b1) value_error(name, "sram_dq_en", 1, sram_dq_en);
				else n_pass++;
			end
		end
		// class follows the byte of the pixel before
		for (int v = line0; v < line0 + 2; v++) begin
			for (int h = 145; h < 784; h++) begin
				if (exp_byte(h - 1, v, k) == 8'h00) begin
					check_word(name, v * line_px + h + 1, hi_word, hi_word, lo_word);
				end else begin
					check_word(name, v * line_px + h + 1, lo_word, hi_word, hi_word);
				end
			end
		end
		finish_test(name);
	endtask

	task automatic test_playback(input string name, input int line, input logic [7:0] fill);
		test_errs = 0;
		wait_pixel(line * line_px - 1);
		rec_n = 1'b1;
		load_sram(fill, 1'b0);
		for (int h = 0; h < line_px; h++) begin
			wait_pixel(line * line_px + h);
			if (sram_we_n !== 1'b1) value_error(name, "sram_we_n", 1, sram_we_n);
			else n_pass++;
			if (sram_dq_en !== 1'b0) value_error(name, "sram_dq_en", 0, sram_dq_en);
			else n_pass++;
		end
		for (int h = 145; h < 784; h++) begin
			if (fill == 8'h00) begin
				check_word(name, line * line_px + h + 1, lo_word, hi_word, lo_word);
			end else begin
				check_word(name, line * line_px + h + 1, hi_word, lo_word, hi_word);
			end
		end
		finish_test(name);
	endtask

	task automatic test_clock_lane();
		test_errs = 0;
		if (clk_bad !== 0) value_error("clock_lane", "bad clock words", 0, clk_bad);
		else n_pass++;
		finish_test("clock_lane");
	endtask

	// ------------------------------------------------------------------------
	// run
	// ------------------------------------------------------------------------
	initial begin
		logic [7:0] key_a;
		logic [7:0] key_b;
		void'($urandom(47040));
		rst    = 1'b1;
		rec_n  = 1'b1;
		key    = 8'h00;
		n_pass = 0;
		n_fail = 0;
		load_sram(8'h00, 1'b1);
		key_a = {1'b0, 7'($urandom)}; // lower bank
		key_b = {1'b1, 7'($urandom)}; // upper bank
		test_reset();
		test_word0();
		test_blank("blank_line0", 0);
		test_blank("blank_line2", 2);
		test_record("record_bank0", 36, key_a);
		test_record("record_bank1", 38, key_b);
		test_playback("playback_zero", 41, 8'h00);
		test_playback("playback_5a", 43, 8'h5a);
		test_clock_lane();
		$display("checks passed %0d, checks failed %0d", n_pass, n_fail);
		if (n_fail == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

	initial begin
		#(run_limit);
		$display("watchdog expired before all tests finished");
		$display("sim failed");
		$finish;
	end

endmodule

// File: dvid_top.sv
module dvid_top (
	input  logic                          latch_high_speed,
	input  logic                          rst,
	input  logic                          rec_n,
	input  logic [7:0]                    key,
	output logic [dvid_pkg::sram_aw-1:0]  sram_addr,
	output logic                          sram_we_n,
	output logic [dvid_pkg::sram_dw-1:0]  sram_dq_out,
	output logic                          sram_dq_en,
	input  logic [dvid_pkg::sram_dw-1:0]  sram_dq_in,
	output logic [1:0]                    tmds_red,
	output logic [1:0]                    tmds_green,
	output logic [1:0]                    tmds_blue,
	output logic [1:0]                    tmds_clk
);
	import dvid_pkg::*;

	logic       pix_stb;
	logic [9:0] h_count;
	logic [9:0] v_count;
	logic       hsync;
	logic       vsync;
	logic       active;
	pix_class_t pix_class;
	symbol_t    sym_red;
	symbol_t    sym_green;
	symbol_t    sym_blue;

	// ------------------------------------------------------------------------
	// timing, frame store, symbol choice, serializer
	// ------------------------------------------------------------------------
	raster_timing raster_timing_i (
		.latch_high_speed (latch_high_speed),
		.rst              (rst),
		.pix_stb          (pix_stb),
		.h_count          (h_count),
		.v_count          (v_count),
		.hsync            (hsync),
		.vsync            (vsync),
		.active           (active)
	);

	frame_store_ctrl frame_store_ctrl_i (
		.latch_high_speed (latch_high_speed),
		.rst              (rst),
		.pix_stb          (pix_stb),
		.active           (active),
		.h_count          (h_count),
		.v_count          (v_count),
		.rec_n            (rec_n),
		.key              (key),
		.sram_addr        (sram_addr),
		.sram_we_n        (sram_we_n),
		.sram_dq_out      (sram_dq_out),
		.sram_dq_en       (sram_dq_en),
		.sram_dq_in       (sram_dq_in),
		.pix_class        (pix_class)
	);

	tmds_symbol_select tmds_symbol_select_i (
		.latch_high_speed (latch_high_speed),
		.rst              (rst),
		.pix_stb          (pix_stb),
		.active           (active),
		.hsync            (hsync),
		.vsync            (vsync),
		.pix_class        (pix_class),
		.sym_red          (sym_red),
		.sym_green        (sym_green),
		.sym_blue         (sym_blue)
	);

	tmds_serializer tmds_serializer_i (
		.latch_high_speed (latch_high_speed),
		.rst              (rst),
		.pix_stb          (pix_stb),
		.sym_red          (sym_red),
		.sym_green        (sym_green),
		.sym_blue         (sym_blue),
		.tmds_red         (tmds_red),
		.tmds_green       (tmds_green),
		.tmds_blue        (tmds_blue),
		.tmds_clk         (tmds_clk)
	);

endmodule

// File: tmds_serializer.sv
module tmds_serializer (
	input  logic               latch_high_speed,
	input  logic               rst,
	input  logic               pix_stb,
	input  dvid_pkg::symbol_t  sym_red,
	input  dvid_pkg::symbol_t  sym_green,
	input  dvid_pkg::symbol_t  sym_blue,
	output logic [1:0]         tmds_red,
	output logic [1:0]         tmds_green,
	output logic [1:0]         tmds_blue,
	output logic [1:0]         tmds_clk
);
	import dvid_pkg::*;

	localparam int n_lanes = 4;

	symbol_t    load_sym [n_lanes]; // word taken on the strobe
	symbol_t    lane     [n_lanes]; // shift registers
	logic [1:0] out_q    [n_lanes]; // bit pair on the pins

	// lane order red, green, blue, clock
	assign load_sym[0] = sym_red;
	assign load_sym[1] = sym_green;
	assign load_sym[2] = sym_blue;
	assign load_sym[3] = clk_sym;

	// ------------------------------------------------------------------------
	// load on the pixel strobe, shift two bits on all other clocks
	// ------------------------------------------------------------------------
	always_ff @(posedge latch_high_speed) begin
		if (rst) begin
			for (int i = 0; i < n_lanes; i++) begin
				lane[i]  <= '0;
				out_q[i] <= '0;
			end
		end else begin
			for (int i = 0; i < n_lanes; i++) begin
				out_q[i] <= lane[i][1:0]; // lowest bits go first
				if (pix_stb) begin
					lane[i] <= load_sym[i];
				end else begin
					lane[i] <= {2'b00, lane[i][sym_w-1:2]};
				end
			end
		end
	end

	assign tmds_red   = out_q[0];
	assign tmds_green = out_q[1];
	assign tmds_blue  = out_q[2];
	assign tmds_clk   = out_q[3];

	// a new word only arrives once the last pair is leaving
	for (genvar g = 0; g < n_lanes; g++) begin : g_lane_chk
		property lane_drained;
			@(posedge latch_high_speed) disable iff (rst)
			pix_stb |-> (lane[g][sym_w-1:2] == '0);
		endproperty

		assert_lane_drained: assert property (lane_drained)
		else $error("lane %0d loaded before it was shifted out", g);
	end

endmodule

// File: tmds_symbol_select.sv
module tmds_symbol_select (
	input  logic                  latch_high_speed,
	input  logic                  rst,
	input  logic                  pix_stb,
	input  logic                  active,
	input  logic                  hsync,
	input  logic                  vsync,
	input  dvid_pkg::pix_class_t  pix_class,
	output dvid_pkg::symbol_t     sym_red,
	output dvid_pkg::symbol_t     sym_green,
	output dvid_pkg::symbol_t     sym_blue
);
	import dvid_pkg::*;

	symbol_t red_next;
	symbol_t green_next;
	symbol_t blue_next;

	// ------------------------------------------------------------------------
	// per pixel mapping
	// ------------------------------------------------------------------------
	always_comb begin
		if (active) begin
			case (pix_class)
				rec_dark: begin
					red_next   = sym_hi;
					green_next = sym_hi;
					blue_next  = sym_lo;
				end
				rec_bright: begin
					red_next   = sym_lo;
					green_next = sym_hi;
					blue_next  = sym_hi;
				end
				play_dark: begin
					red_next   = sym_lo;
					green_next = sym_hi;
					blue_next  = sym_lo;
				end
				default: begin // play_bright
					red_next   = sym_hi;
					green_next = sym_lo;
					blue_next  = sym_hi;
				end
			endcase
		end else begin
			// blanking, syncs ride on the blue lane only
			red_next   = ctl_sym[0];
			green_next = ctl_sym[0];
			blue_next  = ctl_sym[{vsync, hsync}];
		end
	end

	always_ff @(posedge latch_high_speed) begin
		if (rst) begin
			sym_red   <= '0;
			sym_green <= '0;
			sym_blue  <= '0;
		end else if (pix_stb) begin
			sym_red   <= red_next;
			sym_green <= green_next;
			sym_blue  <= blue_next;
		end
	end

endmodule

// File: frame_store_ctrl.sv
module frame_store_ctrl (
	input  logic                          latch_high_speed,
	input  logic                          rst,
	input  logic                          pix_stb,
	input  logic                          active,
	input  logic [9:0]                    h_count,
	input  logic [9:0]                    v_count,
	input  logic                          rec_n,
	input  logic [7:0]                    key,
	output logic [dvid_pkg::sram_aw-1:0]  sram_addr,
	output logic                          sram_we_n,
	output logic [dvid_pkg::sram_dw-1:0]  sram_dq_out,
	output logic                          sram_dq_en,
	input  logic [dvid_pkg::sram_dw-1:0]  sram_dq_in,
	output dvid_pkg::pix_class_t          pix_class
);
	import dvid_pkg::*;

	logic [9:0]         col_off;   // column inside the visible window
	logic [9:0]         row_off;   // line inside the visible window
	logic [sram_aw-1:0] bank_base;
	logic [sram_aw-1:0] addr_next;
	logic [6:0]         pattern;   // xnor test pattern
	logic               pat_set;
	logic [sram_dw-1:0] rec_byte;  // byte being recorded
	logic [sram_dw-1:0] rd_byte;   // byte read back
	logic               we_q;
	logic               wr_mode;

	// ------------------------------------------------------------------------
	// address, half resolution, 320 words per stored line
	// ------------------------------------------------------------------------
	assign col_off   = h_count - 10'(h_bp_end);
	assign row_off   = v_count - 10'(v_bp_end);
	assign bank_base = key[7] ? sram_aw'(bank_offset) : '0;

	assign addr_next = sram_aw'(col_off[9:1])
		+ sram_aw'(row_off[9:1]) * sram_aw'(line_words)
		+ bank_base;

	// record pattern, thresholded by the low key bits
	assign pattern = h_count[6:0] ~^ v_count[6:0];
	assign pat_set = (pattern > key[6:0]);

	always_ff @(posedge latch_high_speed) begin
		if (rst) begin
			sram_addr <= '0;
			rec_byte  <= '0;
			rd_byte   <= '0;
			we_q      <= 1'b1;
			wr_mode   <= 1'b0;
		end else if (pix_stb) begin
			wr_mode <= ~rec_n;
			if (active) begin
				sram_addr <= addr_next;
				rec_byte  <= pat_set ? '1 : '0;
				rd_byte   <= sram_dq_in; // answer for the previous address
				we_q      <= rec_n | addr_next[0]; // write strobe on even addresses
			end else begin
				we_q <= 1'b1; // no writes in blanking
			end
		end
	end

	// ------------------------------------------------------------------------
	// SRAM bus side
	// ------------------------------------------------------------------------
	// rec_n releases the bus at once, not at the next strobe
	assign sram_we_n   = we_q | rec_n;
	assign sram_dq_en  = wr_mode & ~rec_n;
	assign sram_dq_out = rec_byte;

	// class of the byte from the previous strobe
	always_comb begin
		if (!rec_n) begin
			pix_class = (rec_byte == '0) ? rec_dark : rec_bright;
		end else begin
			pix_class = (rd_byte == '0) ? play_dark : play_bright;
		end
	end

	// a write strobe always comes with the data bus driven
	property write_with_bus_driven;
		@(posedge latch_high_speed) disable iff (rst)
		!sram_we_n |-> sram_dq_en;
	endproperty

	assert_write_driven: assert property (write_with_bus_driven)
	else $error("SRAM write strobe with the data bus released");

endmodule

// File: raster_timing.sv
module raster_timing (
	input  logic       latch_high_speed,
	input  logic       rst,
	output logic       pix_stb,
	output logic [9:0] h_count,
	output logic [9:0] v_count,
	output logic       hsync,
	output logic       vsync,
	output logic       active
);
	import dvid_pkg::*;

	logic [2:0] phase; // bit clock phase inside one pixel
	logic       h_last;
	logic       v_last;
	logic       h_window;
	logic       v_window;

	// ------------------------------------------------------------------------
	// pixel strobe, one clock in five
	// ------------------------------------------------------------------------
	assign pix_stb = (phase == 3'(pix_phases - 1));

	always_ff @(posedge latch_high_speed) begin
		if (rst) begin
			phase <= '0;
		end else if (pix_stb) begin
			phase <= '0;
		end else begin
			phase <= phase + 3'd1;
		end
	end

	// ------------------------------------------------------------------------
	// raster walk
	// ------------------------------------------------------------------------
	assign h_last = (h_count == 10'(h_total - 1));
	assign v_last = (v_count == 10'(v_total - 1));

	always_ff @(posedge latch_high_speed) begin
		if (rst) begin
			h_count <= '0;
			v_count <= '0;
		end else if (pix_stb) begin
			if (h_last) begin
				h_count <= '0;
				// end of line, step the line counter
				if (v_last) begin
					v_count <= '0;
				end else begin
					v_count <= v_count + 10'd1;
				end
			end else begin
				h_count <= h_count + 10'd1;
			end
		end
	end

	// sync levels, active high
	assign hsync = (h_count < h_pulse);
	assign vsync = (v_count < v_pulse);

	// visible window between the porches
	assign h_window = (h_count >= h_bp_end) && (h_count < h_fp_start);
	assign v_window = (v_count >= v_bp_end) && (v_count < v_fp_start);
	assign active   = h_window && v_window;

	// strobes keep a full pixel apart, the serializer relies on it
	property stb_spacing;
		@(posedge latch_high_speed) disable iff (rst)
		pix_stb |=> !pix_stb [*(pix_phases - 1)];
	endproperty

	assert_stb_spacing: assert property (stb_spacing)
	else $error("pix_stb repeated within one pixel");

endmodule

// File: dvid_pkg.sv
package dvid_pkg;

	// ------------------------------------------------------------------------
	// raster timing, 640x480 visible inside an 800x525 frame
	// ------------------------------------------------------------------------
	localparam int h_total    = 800; // pixels per line
	localparam int v_total    = 525; // lines per frame
	localparam int h_pulse    = 96;  // hsync length
	localparam int v_pulse    = 2;   // vsync length
	localparam int h_bp_end   = 144; // 96 sync + 48 back porch
	localparam int h_fp_start = 784; // 800 - 16 front porch
	localparam int v_bp_end   = 35;  // 2 sync + 33 back porch
	localparam int v_fp_start = 515; // 525 - 10 front porch

	// bit clock runs five times the pixel rate, two bits per clock
	localparam int pix_phases = 5;

	// ------------------------------------------------------------------------
	// TMDS symbols
	// ------------------------------------------------------------------------
	localparam int sym_w = 10;

	typedef logic [sym_w-1:0] symbol_t;

	// restricted data alphabet, five ones in every word so no DC tracking
	localparam symbol_t sym_hi = 10'b1011110000;
	localparam symbol_t sym_lo = 10'b0111110000;

	// control period words, index is {vsync,hsync}
	localparam symbol_t ctl_sym [0:3] = '{
		10'b1101010100,
		10'b0010101011,
		10'b0101010100,
		10'b1010101011
	};

	// clock lane, five high then five low per pixel
	localparam symbol_t clk_sym = 10'b0000011111;

	// ------------------------------------------------------------------------
	// external frame store
	// ------------------------------------------------------------------------
	localparam int sram_aw     = 18;
	localparam int sram_dw     = 8;
	localparam int line_words  = 320;   // one stored line at half resolution
	localparam int bank_offset = 78000; // second picture, picked by key bit 7

	// what the current pixel shows
	typedef enum logic [1:0] {
		rec_dark,    // recording, byte zero
		rec_bright,  // recording, byte all ones
		play_dark,   // playback, byte zero
		play_bright  // playback, anything else
	} pix_class_t;

endpackage
